// ==== compile.f ====
rtl/softmax_pkg.sv
rtl/max_tracker.sv
rtl/exp2_stage.sv
rtl/denominator_acc.sv
rtl/reciprocal_divider.sv
rtl/normalize_stage.sv
rtl/softmax_ctrl.sv
rtl/softmax_top.sv
test/softmax_tb.sv

// ==== rtl/denominator_acc.sv ====
`timescale 1ns/1ps

module denominator_acc (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   clear_i,
    input  logic                   clear_regs_i,
    input  softmax_pkg::exp_item_t item_i,
    input  logic                   valid_i,
    output logic                   ready_o,
    output softmax_pkg::acc_t      denominator_o,
    output logic                   last_done_o
);

    softmax_pkg::acc_t lane_sum;
    softmax_pkg::acc_t scaled;
    logic              accept;

    assign ready_o = 1'b1;
    assign accept  = valid_i & ready_o;

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < softmax_pkg::N_LANES; i++) begin
            lane_sum = lane_sum + softmax_pkg::acc_t'(item_i.exps[i]);
        end
        // Old terms rescaled to the new maximum
        // shifts of ACC_W and more leave nothing
        scaled = denominator_o >> item_i.shift;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            denominator_o <= '0;
            last_done_o   <= 1'b0;
        end else if (clear_i || clear_regs_i) begin
            denominator_o <= '0;
            last_done_o   <= 1'b0;
        end else begin
            last_done_o <= accept & item_i.last;
            if (accept) begin
                denominator_o <= scaled + lane_sum;
            end
        end
    end

endmodule

// ==== rtl/exp2_stage.sv ====
`timescale 1ns/1ps

module exp2_stage (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   clear_i,
    input  softmax_pkg::max_item_t item_i,
    input  logic                   valid_i,
    output logic                   ready_o,
    output softmax_pkg::exp_item_t item_o,
    output logic                   acc_valid_o,
    input  logic                   acc_ready_i,
    output logic                   norm_valid_o,
    input  logic                   norm_ready_i
);

    softmax_pkg::exp_item_t next_item;
    logic                   valid_q;
    logic                   down_ready;
    logic                   accept;

    // Held item goes to the consumer of its own pass
    assign down_ready   = item_o.norm ? norm_ready_i : acc_ready_i;
    assign ready_o      = ~valid_q | down_ready;
    assign accept       = valid_i & ready_o;
    assign acc_valid_o  = valid_q & ~item_o.norm;
    assign norm_valid_o = valid_q & item_o.norm;

    always_comb begin
        logic [softmax_pkg::SCORE_W:0] diff;
        next_item.shift = item_i.shift;
        next_item.last  = item_i.last;
        next_item.norm  = item_i.norm;
        for (int i = 0; i < softmax_pkg::N_LANES; i++) begin
            diff = $signed(item_i.ref_max) - $signed(item_i.scores[i]);
            // Differences of 16 and above shift the one out completely
            next_item.exps[i] = softmax_pkg::exp_t'(1 << softmax_pkg::EXP_ONE_SHIFT) >> diff;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (down_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            item_o <= next_item;
        end
    end

endmodule

// ==== rtl/max_tracker.sv ====
`timescale 1ns/1ps

module max_tracker (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    clear_i,
    input  logic                    clear_regs_i,
    input  softmax_pkg::phase_e     phase_i,
    input  softmax_pkg::score_vec_t in_i,
    input  logic                    valid_i,
    output logic                    ready_o,
    output softmax_pkg::max_item_t  item_o,
    output logic                    valid_o,
    input  logic                    ready_i,
    output softmax_pkg::score_t     max_o
);

    softmax_pkg::score_t max_q;
    softmax_pkg::score_t vec_max;
    softmax_pkg::score_t new_max;
    logic                accumulate;
    logic                accept;

    assign accumulate = (phase_i == softmax_pkg::ACCUMULATE);
    assign ready_o    = ~valid_o | ready_i;
    // Input is only taken in the two streaming phases
    assign accept     = valid_i & ready_o & (accumulate | (phase_i == softmax_pkg::NORMALIZE));
    assign max_o      = max_q;

    always_comb begin
        vec_max = in_i.scores[0];
        for (int i = 1; i < softmax_pkg::N_LANES; i++) begin
            if ($signed(in_i.scores[i]) > $signed(vec_max)) begin
                vec_max = in_i.scores[i];
            end
        end
        // Maximum is frozen during pass 2
        new_max = max_q;
        if (accumulate && ($signed(vec_max) > $signed(max_q))) begin
            new_max = vec_max;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
            max_q   <= {1'b1, {(softmax_pkg::SCORE_W-1){1'b0}}};
        end else if (clear_i) begin
            valid_o <= 1'b0;
            max_q   <= {1'b1, {(softmax_pkg::SCORE_W-1){1'b0}}};
        end else begin
            if (accept) begin
                valid_o <= 1'b1;
            end else if (ready_i) begin
                valid_o <= 1'b0;
            end
            if (clear_regs_i) begin
                max_q <= {1'b1, {(softmax_pkg::SCORE_W-1){1'b0}}};
            end else if (accept) begin
                max_q <= new_max;
            end
        end
    end

    // First vector gets a large shift but the denominator is still zero then
    always_ff @(posedge clk_i) begin
        if (accept) begin
            item_o.scores  <= in_i.scores;
            item_o.ref_max <= new_max;
            item_o.shift   <= new_max - max_q;
            item_o.last    <= in_i.last;
            item_o.norm    <= ~accumulate;
        end
    end

endmodule

// ==== rtl/normalize_stage.sv ====
`timescale 1ns/1ps

module normalize_stage (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   clear_i,
    input  softmax_pkg::exp_item_t item_i,
    input  logic                   valid_i,
    output logic                   ready_o,
    input  softmax_pkg::recip_t    recip_i,
    output softmax_pkg::prob_vec_t out_o,
    output logic                   valid_o,
    input  logic                   ready_i,
    output logic                   last_done_o
);

    softmax_pkg::prob_vec_t next_out;
    logic                   accept;

    assign ready_o     = ~valid_o | ready_i;
    assign accept      = valid_i & ready_o;
    assign last_done_o = valid_o & ready_i & out_o.last;

    always_comb begin
        logic [softmax_pkg::EXP_W+softmax_pkg::RECIP_W-1:0] product;
        next_out.last = item_i.last;
        for (int i = 0; i < softmax_pkg::N_LANES; i++) begin
            product = item_i.exps[i] * recip_i;
            next_out.probs[i] = product[softmax_pkg::PROB_SHIFT +: softmax_pkg::EXP_W];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
        end else if (clear_i) begin
            valid_o <= 1'b0;
        end else if (accept) begin
            valid_o <= 1'b1;
        end else if (ready_i) begin
            valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            out_o <= next_out;
        end
    end

endmodule

// ==== rtl/reciprocal_divider.sv ====
`timescale 1ns/1ps

module reciprocal_divider (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                clear_i,
    input  logic                start_i,
    input  softmax_pkg::acc_t   denominator_i,
    output logic                done_o,
    output softmax_pkg::recip_t recip_o
);

    logic                                  busy_q;
    logic [$clog2(softmax_pkg::RECIP_K+1):0] count_q;
    softmax_pkg::acc_t                     divisor_q;
    softmax_pkg::acc_t                     rem_q;
    softmax_pkg::acc_t                     step_div;
    softmax_pkg::acc_t                     step_rem;
    logic [softmax_pkg::ACC_W:0]           trial;
    logic [softmax_pkg::ACC_W:0]           trial_sub;
    logic                                  q_bit;

    // Dividend has a single one at bit RECIP_K
    // so only the first step brings in a one
    always_comb begin
        step_div  = start_i ? denominator_i : divisor_q;
        trial     = start_i ? {{softmax_pkg::ACC_W{1'b0}}, 1'b1} : {rem_q, 1'b0};
        trial_sub = trial - {1'b0, step_div};
        q_bit     = (trial >= {1'b0, step_div});
        step_rem  = q_bit ? trial_sub[softmax_pkg::ACC_W-1:0] : trial[softmax_pkg::ACC_W-1:0];
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q  <= 1'b0;
            count_q <= '0;
            done_o  <= 1'b0;
        end else if (clear_i) begin
            busy_q  <= 1'b0;
            count_q <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy_q  <= 1'b1;
                count_q <= 1;
            end else if (busy_q) begin
                count_q <= count_q + 1'b1;
                if (count_q == softmax_pkg::RECIP_K) begin
                    busy_q <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    // Quotient bits enter from the bottom and the top ones fall off
    always_ff @(posedge clk_i) begin
        if (start_i || busy_q) begin
            divisor_q <= step_div;
            rem_q     <= step_rem;
            recip_o   <= {recip_o[softmax_pkg::RECIP_W-2:0], q_bit};
        end
    end

endmodule

// ==== rtl/softmax_ctrl.sv ====
`timescale 1ns/1ps

module softmax_ctrl (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                clear_i,
    input  logic                in_valid_i,
    input  logic                in_ready_i,
    input  logic                in_last_i,
    input  logic                acc_last_done_i,
    input  logic                norm_last_done_i,
    input  logic                recip_done_i,
    output softmax_pkg::phase_e phase_o,
    output logic                in_enable_o,
    output logic                recip_start_o,
    output logic                clear_regs_o
);

    softmax_pkg::phase_e state_q;
    softmax_pkg::phase_e state_d;
    logic                last_in;

    assign phase_o       = state_q;
    assign in_enable_o   = in_ready_i & ((state_q == softmax_pkg::ACCUMULATE) |
                                         (state_q == softmax_pkg::NORMALIZE));
    assign last_in       = (state_q == softmax_pkg::ACCUMULATE) & in_valid_i &
                           in_enable_o & in_last_i;
    assign recip_start_o = (state_q == softmax_pkg::DRAIN) & acc_last_done_i;
    // Wipes maximum and denominator for the next run
    assign clear_regs_o  = (state_q == softmax_pkg::NORMALIZE) & norm_last_done_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            softmax_pkg::ACCUMULATE: begin
                if (last_in) begin
                    state_d = softmax_pkg::DRAIN;
                end
            end
            softmax_pkg::DRAIN: begin
                if (recip_start_o) begin
                    state_d = softmax_pkg::INVERT;
                end
            end
            softmax_pkg::INVERT: begin
                if (recip_done_i) begin
                    state_d = softmax_pkg::NORMALIZE;
                end
            end
            softmax_pkg::NORMALIZE: begin
                if (clear_regs_o) begin
                    state_d = softmax_pkg::ACCUMULATE;
                end
            end
            default: state_d = softmax_pkg::ACCUMULATE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= softmax_pkg::ACCUMULATE;
        end else if (clear_i) begin
            state_q <= softmax_pkg::ACCUMULATE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== rtl/softmax_pkg.sv ====
package softmax_pkg;

    localparam int N_LANES       = 4;
    localparam int SCORE_W       = 8;
    localparam int EXP_W         = 16;
    localparam int EXP_ONE_SHIFT = 15;
    localparam int ACC_W         = 24;
    localparam int SHIFT_W       = 8;
    localparam int RECIP_K       = 31;
    localparam int RECIP_W       = 17;
    localparam int PROB_SHIFT    = 16;

    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic [EXP_W-1:0]          exp_t;
    typedef logic [ACC_W-1:0]          acc_t;
    typedef logic [RECIP_W-1:0]        recip_t;

    typedef enum logic [1:0] {
        ACCUMULATE = 2'd0,
        DRAIN      = 2'd1,
        INVERT     = 2'd2,
        NORMALIZE  = 2'd3
    } phase_e;

    typedef struct packed {
        score_t [N_LANES-1:0] scores;
        logic                 last;
    } score_vec_t;

    typedef struct packed {
        score_t [N_LANES-1:0] scores;
        score_t               ref_max;
        logic [SHIFT_W-1:0]   shift;
        logic                 last;
        logic                 norm;
    } max_item_t;

    typedef struct packed {
        exp_t [N_LANES-1:0] exps;
        logic [SHIFT_W-1:0] shift;
        logic               last;
        logic               norm;
    } exp_item_t;

    typedef struct packed {
        exp_t [N_LANES-1:0] probs;
        logic               last;
    } prob_vec_t;

    typedef struct packed {
        phase_e phase;
        score_t max;
        acc_t   denominator;
    } status_t;

endpackage

// ==== rtl/softmax_top.sv ====
`timescale 1ns/1ps

module softmax_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    clear_i,
    input  softmax_pkg::score_vec_t in_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    output softmax_pkg::prob_vec_t  out_o,
    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    output softmax_pkg::status_t    status_o
);

    softmax_pkg::phase_e    phase;
    softmax_pkg::max_item_t max_item;
    softmax_pkg::exp_item_t exp_item;
    softmax_pkg::score_t    cur_max;
    softmax_pkg::acc_t      denominator;
    softmax_pkg::recip_t    recip;
    logic                   tracker_ready;
    logic                   max_valid;
    logic                   exp_ready;
    logic                   acc_valid;
    logic                   acc_ready;
    logic                   norm_valid;
    logic                   norm_ready;
    logic                   acc_last_done;
    logic                   norm_last_done;
    logic                   recip_start;
    logic                   recip_done;
    logic                   clear_regs;

    assign status_o.phase       = phase;
    assign status_o.max         = cur_max;
    assign status_o.denominator = denominator;

    softmax_ctrl i_ctrl (
        .clk_i            ( clk_i          ),
        .rst_ni           ( rst_ni         ),
        .clear_i          ( clear_i        ),
        .in_valid_i       ( in_valid_i     ),
        .in_ready_i       ( tracker_ready  ),
        .in_last_i        ( in_i.last      ),
        .acc_last_done_i  ( acc_last_done  ),
        .norm_last_done_i ( norm_last_done ),
        .recip_done_i     ( recip_done     ),
        .phase_o          ( phase          ),
        .in_enable_o      ( in_ready_o     ),
        .recip_start_o    ( recip_start    ),
        .clear_regs_o     ( clear_regs     )
    );

    max_tracker i_max_tracker (
        .clk_i        ( clk_i         ),
        .rst_ni       ( rst_ni        ),
        .clear_i      ( clear_i       ),
        .clear_regs_i ( clear_regs    ),
        .phase_i      ( phase         ),
        .in_i         ( in_i          ),
        .valid_i      ( in_valid_i    ),
        .ready_o      ( tracker_ready ),
        .item_o       ( max_item      ),
        .valid_o      ( max_valid     ),
        .ready_i      ( exp_ready     ),
        .max_o        ( cur_max       )
    );

    exp2_stage i_exp2_stage (
        .clk_i        ( clk_i      ),
        .rst_ni       ( rst_ni     ),
        .clear_i      ( clear_i    ),
        .item_i       ( max_item   ),
        .valid_i      ( max_valid  ),
        .ready_o      ( exp_ready  ),
        .item_o       ( exp_item   ),
        .acc_valid_o  ( acc_valid  ),
        .acc_ready_i  ( acc_ready  ),
        .norm_valid_o ( norm_valid ),
        .norm_ready_i ( norm_ready )
    );

    denominator_acc i_denominator_acc (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .clear_i       ( clear_i       ),
        .clear_regs_i  ( clear_regs    ),
        .item_i        ( exp_item      ),
        .valid_i       ( acc_valid     ),
        .ready_o       ( acc_ready     ),
        .denominator_o ( denominator   ),
        .last_done_o   ( acc_last_done )
    );

    reciprocal_divider i_reciprocal_divider (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .clear_i       ( clear_i     ),
        .start_i       ( recip_start ),
        .denominator_i ( denominator ),
        .done_o        ( recip_done  ),
        .recip_o       ( recip       )
    );

    normalize_stage i_normalize_stage (
        .clk_i       ( clk_i          ),
        .rst_ni      ( rst_ni         ),
        .clear_i     ( clear_i        ),
        .item_i      ( exp_item       ),
        .valid_i     ( norm_valid     ),
        .ready_o     ( norm_ready     ),
        .recip_i     ( recip          ),
        .out_o       ( out_o          ),
        .valid_o     ( out_valid_o    ),
        .ready_i     ( out_ready_i    ),
        .last_done_o ( norm_last_done )
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module softmax_tb -f compile.f -o softmax_sim

sim_output=$(./obj_dir/softmax_sim || true)
echo "$sim_output"

if echo "$sim_output" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi

// ==== test/softmax_input.txt ====
# S s0 s1 s2 s3 = one score vector, D = expected denominator, M = expected maximum
# P p0 p1 p2 p3 = expected probabilities, one line for each S line of the run in order
S 0 -1 -2 -3
S 2 1 0 -20
S 1 1 -5 3
D 85632
M 3
P 1567 783 391 195
P 6269 3134 1567 0
P 3134 3134 48 12539
S 100 90 84 85
S 99 100 50 -128
D 81953
M 100
P 13101 12 0 0
P 6550 13101 0 0
S -50 -53 -60 -70
S -33 -40 -45 -52
D 33032
M -33
P 0 0 0 0
P 32506 253 7 0

// ==== test/softmax_tb.sv ====
`timescale 1ns/1ps

module softmax_tb;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   clear_i;
    softmax_pkg::score_vec_t in_i;
    logic                   in_valid_i;
    logic                   in_ready_o;
    softmax_pkg::prob_vec_t out_o;
    logic                   out_valid_o;
    logic                   out_ready_i = 1'b0;
    softmax_pkg::status_t   status_o;

    // Stimulus and expectations from the input file
    logic [31:0] vec_data[$];
    int          vec_run[$];
    int          run_first[$];
    int          run_len[$];
    logic [63:0] prob_data[$];
    int          den_exp[$];
    int          max_exp[$];

    logic [31:0] lfsr_q      = 32'hb25a;
    logic        ready_next  = 1'b0;
    logic        offer_next  = 1'b0;
    int          out_count   = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    softmax_top softmax_top_inst (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .clear_i     ( clear_i     ),
        .in_i        ( in_i        ),
        .in_valid_i  ( in_valid_i  ),
        .in_ready_o  ( in_ready_o  ),
        .out_o       ( out_o       ),
        .out_valid_o ( out_valid_o ),
        .out_ready_i ( out_ready_i ),
        .status_o    ( status_o    )
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic signed [63:0] expected,
                               input logic signed [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic read_input_file();
        int          fd;
        int          code;
        int          ch;
        int          a;
        int          b;
        int          c;
        int          d;
        logic [7:0]  tag;
        logic [7:0]  prev_tag;
        logic        done;
        fd = $fopen("test/softmax_input.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open test/softmax_input.txt");
        end
        prev_tag = 8'h00;
        done     = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (tag == "S" || tag == "P") begin
                code = $fscanf(fd, "%d %d %d %d", a, b, c, d);
                if (code != 4) begin
                    abort_run("Input file has a line with fewer than four values");
                end
                if (tag == "P") begin
                    prob_data.push_back({16'(d), 16'(c), 16'(b), 16'(a)});
                end else begin
                    // An S line after expectations opens the next run
                    if (prev_tag != "S") begin
                        run_first.push_back(vec_data.size());
                        run_len.push_back(0);
                    end
                    vec_data.push_back({8'(d), 8'(c), 8'(b), 8'(a)});
                    vec_run.push_back(run_first.size() - 1);
                    run_len[run_len.size() - 1] += 1;
                end
            end else if (tag == "D" || tag == "M") begin
                code = $fscanf(fd, "%d", a);
                if (code != 1) begin
                    abort_run("Input file has a D or M line without a value");
                end
                if (tag == "D") begin
                    den_exp.push_back(a);
                end else begin
                    max_exp.push_back(a);
                end
            end else begin
                abort_run("Input file has a line with an unknown tag");
            end
            prev_tag = tag;
        end
        $fclose(fd);
        if (prob_data.size() != vec_data.size() || den_exp.size() != run_first.size() ||
            max_exp.size() != run_first.size()) begin
            abort_run("Input file does not give every expectation for every run");
        end
    endtask

    // Holds valid with stable data until the DUT takes the vector
    task automatic send_vectors(input int first, input int count);
        int   sent;
        logic took;
        sent = 0;
        took = 1'b0;
        while (sent < count) begin
            @(posedge clk_i);
            if (!in_valid_i || took) begin
                if (offer_next) begin
                    in_i.scores <= vec_data[first + sent];
                    in_i.last   <= (sent == count - 1);
                    in_valid_i  <= 1'b1;
                end else begin
                    in_valid_i <= 1'b0;
                end
            end
            @(negedge clk_i);
            took = in_valid_i && in_ready_o;
            if (took) begin
                sent++;
            end
        end
        @(posedge clk_i);
        in_valid_i <= 1'b0;
    endtask

    task automatic wait_phase(input softmax_pkg::phase_e phase);
        do begin
            @(negedge clk_i);
        end while (status_o.phase != phase);
    endtask

    always @(negedge clk_i) begin
        lfsr_q     = lfsr_next(lfsr_q);
        ready_next = lfsr_q[0];
        lfsr_q     = lfsr_next(lfsr_q);
        offer_next = lfsr_q[0];
    end

    always @(posedge clk_i) begin
        out_ready_i <= ready_next;
    end

    // Output handshake is decided here and completes on the next rising edge
    always @(negedge clk_i) begin
        int   run;
        logic exp_last;
        if (rst_ni && out_valid_o && out_ready_i) begin
            if (out_count >= prob_data.size()) begin
                abort_run("DUT produced more output vectors than the input file expects");
            end
            run      = vec_run[out_count];
            exp_last = (out_count == run_first[run] + run_len[run] - 1);
            for (int j = 0; j < softmax_pkg::N_LANES; j++) begin
                check_value($sformatf("vector %0d lane %0d", out_count, j),
                            64'(prob_data[out_count][16*j +: 16]), 64'(out_o.probs[j]));
            end
            check_value($sformatf("vector %0d last", out_count), 64'(exp_last),
                        64'(out_o.last));
            out_count = out_count + 1;
        end
    end

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            abort_run($sformatf("Timeout: the runs did not finish within %0d cycles",
                                cycle_limit));
        end
    end

    initial begin
        int first;
        int count;
        rst_ni     = 1'b0;
        clear_i    = 1'b0;
        in_valid_i = 1'b0;
        in_i       = '0;
        read_input_file();
        cycle_limit = 200 * run_first.size() + 8 * vec_data.size();
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int r = 0; r < run_first.size(); r++) begin
            first = run_first[r];
            count = run_len[r];
            send_vectors(first, count);
            wait_phase(softmax_pkg::INVERT);
            check_value($sformatf("run %0d max", r), 64'(max_exp[r]), 64'(status_o.max));
            check_value($sformatf("run %0d denominator", r), 64'(den_exp[r]),
                        64'(status_o.denominator));
            check_value($sformatf("run %0d in_ready in INVERT", r), 64'(0),
                        64'(in_ready_o));
            wait_phase(softmax_pkg::NORMALIZE);
            send_vectors(first, count);
            while (out_count < first + count) begin
                @(posedge clk_i);
            end
            wait_phase(softmax_pkg::ACCUMULATE);
            // No output may linger once the run has ended
            check_value($sformatf("run %0d out_valid after last vector", r), 64'(0),
                        64'(out_valid_o));
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule
